//--- Makefile
TOP := tb_execute_stage

.PHONY: all lint clean

all:
	verilator --binary --assert -j 0 -f project.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

lint:
	verilator --lint-only -Wall --assert -f project.f --top-module execute_stage

clean:
	rm -rf obj_dir

//--- logic/alu.sv
`default_nettype none

`include "execute_settings.svh"

module alu
    import execute_pkg::*;
(
    input  wire alu_op_t                 i_alu_op,
    input  wire data_t                   i_operand_a,
    input  wire data_t                   i_operand_b,
    input  wire logic [`EXE_REG_W-1:0]   i_shamt,
    output data_t                        o_result
);

    logic [`EXE_REG_W-1:0] var_shamt;

    // Variable shifts use the low bits of rs.
    assign var_shamt = i_operand_a[`EXE_REG_W-1:0];

    always_comb begin
        case (i_alu_op)
            ALU_SLL: begin
                o_result = i_operand_b << i_shamt;
            end
            ALU_SRL: begin
                o_result = i_operand_b >> i_shamt;
            end
            ALU_SRA: begin
                o_result = data_t'($signed(i_operand_b) >>> i_shamt);
            end
            ALU_SLLV: begin
                o_result = i_operand_b << var_shamt;
            end
            ALU_SRLV: begin
                o_result = i_operand_b >> var_shamt;
            end
            ALU_SRAV: begin
                o_result = data_t'($signed(i_operand_b) >>> var_shamt);
            end
            ALU_ADD:  o_result = i_operand_a + i_operand_b;
            ALU_SUB:  o_result = i_operand_a - i_operand_b;
            ALU_AND:  o_result = i_operand_a & i_operand_b;
            ALU_OR:   o_result = i_operand_a | i_operand_b;
            ALU_XOR:  o_result = i_operand_a ^ i_operand_b;
            ALU_NOR:  o_result = ~(i_operand_a | i_operand_b);
            ALU_SLT: begin
                if ($signed(i_operand_a) < $signed(i_operand_b)) begin
                    o_result = data_t'(1);
                end
                else begin
                    o_result = '0;
                end
            end
            ALU_LUI: begin
                o_result = i_operand_b << 16;
            end
            // Return address is the next word.
            ALU_LINK: o_result = i_operand_a + data_t'(1);
            default:  o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
`default_nettype none

`include "execute_settings.svh"

module branch_unit
    import execute_pkg::*;
(
    input  wire branch_t i_branch,
    input  wire logic    i_enable_stage,
    input  wire addr_t   i_adder_pc,
    input  wire data_t   i_imm,
    input  wire data_t   i_data_a,
    input  wire data_t   i_data_b,
    output logic         o_branch_taken,
    output addr_t        o_branch_target
);

    addr_t rel_target;
    logic  operands_equal;
    logic  condition;

    // Relative target wraps within the word address space.
    assign rel_target     = i_adder_pc + i_imm[`EXE_ADDR_W-1:0];
    assign operands_equal = (i_data_a == i_data_b);

    //////////////////////////////
    // Condition and target.
    //////////////////////////////
    always_comb begin
        case (i_branch)
            BR_BEQ: begin
                condition       = operands_equal;
                o_branch_target = rel_target;
            end
            BR_BNE: begin
                condition       = !operands_equal;
                o_branch_target = rel_target;
            end
            BR_JUMP: begin
                condition       = 1'b1;
                o_branch_target = i_imm[`EXE_ADDR_W-1:0];
            end
            BR_JUMP_REG: begin
                condition       = 1'b1;
                o_branch_target = i_data_a[`EXE_ADDR_W-1:0];
            end
            default: begin
                condition       = 1'b0;
                o_branch_target = rel_target;
            end
        endcase
    end

    // No redirect while the stage is idle.
    assign o_branch_taken = condition && i_enable_stage;

endmodule

`default_nettype wire

//--- logic/ex_mem_latch.sv
`default_nettype none

module ex_mem_latch
    import execute_pkg::*;
(
    input  wire logic     i_clock,
    input  wire logic     i_soft_reset,
    input  wire logic     i_enable_pipeline,
    input  wire logic     i_reg_write,
    input  wire logic     i_mem_read,
    input  wire logic     i_mem_write,
    input  wire logic     i_mem_to_reg,
    input  wire logic     i_halt,
    input  wire logic     i_branch_taken,
    input  wire bytesel_t i_byte_sel,
    input  wire data_t    i_result,
    input  wire data_t    i_store_data,
    input  wire reg_idx_t i_dest_reg,
    input  wire addr_t    i_branch_target,
    output logic          o_reg_write,
    output logic          o_mem_read,
    output logic          o_mem_write,
    output logic          o_mem_to_reg,
    output logic          o_halt,
    output logic          o_branch_taken_q,
    output bytesel_t      o_byte_sel,
    output data_t         o_result,
    output data_t         o_store_data,
    output reg_idx_t      o_dest_reg,
    output addr_t         o_branch_target_q
);

    //////////////////////////////
    // EX/MEM register.
    //////////////////////////////
    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_reg_write       <= 1'b0;
            o_mem_read        <= 1'b0;
            o_mem_write       <= 1'b0;
            o_mem_to_reg      <= 1'b0;
            o_halt            <= 1'b0;
            o_branch_taken_q  <= 1'b0;
            o_byte_sel        <= '0;
            o_result          <= '0;
            o_store_data      <= '0;
            o_dest_reg        <= '0;
            o_branch_target_q <= '0;
        end
        else if (i_enable_pipeline) begin
            o_reg_write       <= i_reg_write;
            o_mem_read        <= i_mem_read;
            o_mem_write       <= i_mem_write;
            o_mem_to_reg      <= i_mem_to_reg;
            o_halt            <= i_halt;
            o_branch_taken_q  <= i_branch_taken;
            o_byte_sel        <= i_byte_sel;
            o_result          <= i_result;
            o_store_data      <= i_store_data;
            o_dest_reg        <= i_dest_reg;
            o_branch_target_q <= i_branch_target;
        end
        // Stalled, everything holds.
    end

endmodule

`default_nettype wire

//--- logic/execute_pkg.sv
`default_nettype none

`include "execute_settings.svh"

package execute_pkg;

    typedef logic [`EXE_DATA_W-1:0]    data_t;
    typedef logic [`EXE_ADDR_W-1:0]    addr_t;
    typedef logic [`EXE_REG_W-1:0]     reg_idx_t;
    typedef logic [`EXE_BYTESEL_W-1:0] bytesel_t;

    // Codes match the decode stage ALU control.
    typedef enum logic [`EXE_ALU_W-1:0] {
        ALU_SLL  = 4'd0,
        ALU_SRL  = 4'd1,
        ALU_SRA  = 4'd2,
        ALU_SLLV = 4'd3,
        ALU_SRLV = 4'd4,
        ALU_SRAV = 4'd5,
        ALU_ADD  = 4'd6,
        ALU_SUB  = 4'd7,
        ALU_AND  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_XOR  = 4'd10,
        ALU_NOR  = 4'd11,
        ALU_SLT  = 4'd12,
        ALU_LUI  = 4'd13,
        ALU_LINK = 4'd14
    } alu_op_t;

    typedef enum logic [`EXE_BRANCH_W-1:0] {
        BR_NONE     = 3'd0,
        BR_BEQ      = 3'd1,
        BR_BNE      = 3'd2,
        BR_JUMP     = 3'd3,
        BR_JUMP_REG = 3'd4
    } branch_t;

    typedef enum logic [`EXE_FWD_W-1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_t;

endpackage

`default_nettype wire

//--- logic/execute_settings.svh
`ifndef EXECUTE_SETTINGS_SVH
`define EXECUTE_SETTINGS_SVH

// Data word width.
`define EXE_DATA_W 32

// Instruction memory is word addressed.
`define EXE_ADDR_W 10

// Register file index width.
`define EXE_REG_W 5

// ALU control code width.
`define EXE_ALU_W 4

// Branch kind code width.
`define EXE_BRANCH_W 3

// Data memory access size code.
`define EXE_BYTESEL_W 3

// Forwarding source select width.
`define EXE_FWD_W 2

`endif

//--- logic/execute_stage.sv
`default_nettype none

module execute_stage
    import execute_pkg::*;
(
    input  wire logic     i_clock,
    input  wire logic     i_soft_reset,
    input  wire logic     i_enable_pipeline,
    input  wire logic     i_enable_stage,
    input  wire branch_t  i_branch,
    input  wire addr_t    i_adder_pc,
    input  wire data_t    i_data_a,
    input  wire data_t    i_data_b,
    input  wire data_t    i_imm,
    input  wire reg_idx_t i_reg_rs,
    input  wire reg_idx_t i_reg_rt,
    input  wire reg_idx_t i_reg_rd,
    input  wire logic     i_halt,
    input  wire logic     i_reg_dst,
    input  wire logic     i_reg_write,
    input  wire logic     i_alu_src,
    input  wire logic     i_mem_read,
    input  wire logic     i_mem_write,
    input  wire logic     i_mem_to_reg,
    input  wire alu_op_t  i_alu_op,
    input  wire bytesel_t i_byte_sel,
    input  wire logic     i_wb_reg_write,
    input  wire reg_idx_t i_wb_dest,
    input  wire data_t    i_data_forward_mem,
    input  wire data_t    i_data_forward_wb,
    output logic          o_branch_taken,
    output addr_t         o_branch_target,
    output logic          o_reg_write,
    output logic          o_mem_read,
    output logic          o_mem_write,
    output logic          o_mem_to_reg,
    output logic          o_halt,
    output logic          o_branch_taken_q,
    output bytesel_t      o_byte_sel,
    output data_t         o_result,
    output data_t         o_store_data,
    output reg_idx_t      o_dest_reg,
    output addr_t         o_branch_target_q
);

    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    data_t    fwd_data_a;
    data_t    fwd_data_b;
    data_t    operand_a;
    data_t    operand_b;
    data_t    alu_result;
    reg_idx_t dest_reg;

    // MEM stage hazard info comes from our own latch.
    forwarding_unit u_forwarding_unit (
        .i_reg_rs        (i_reg_rs),
        .i_reg_rt        (i_reg_rt),
        .i_mem_reg_write (o_reg_write),
        .i_mem_dest      (o_dest_reg),
        .i_wb_reg_write  (i_wb_reg_write),
        .i_wb_dest       (i_wb_dest),
        .o_fwd_a         (fwd_a),
        .o_fwd_b         (fwd_b)
    );

    operand_select u_operand_select (
        .i_fwd_a            (fwd_a),
        .i_fwd_b            (fwd_b),
        .i_data_a           (i_data_a),
        .i_data_b           (i_data_b),
        .i_imm              (i_imm),
        .i_data_forward_mem (i_data_forward_mem),
        .i_data_forward_wb  (i_data_forward_wb),
        .i_adder_pc         (i_adder_pc),
        .i_alu_src          (i_alu_src),
        .i_reg_dst          (i_reg_dst),
        .i_alu_op           (i_alu_op),
        .i_reg_rt           (i_reg_rt),
        .i_reg_rd           (i_reg_rd),
        .o_fwd_data_a       (fwd_data_a),
        .o_fwd_data_b       (fwd_data_b),
        .o_operand_a        (operand_a),
        .o_operand_b        (operand_b),
        .o_dest_reg         (dest_reg)
    );

    alu u_alu (
        .i_alu_op    (i_alu_op),
        .i_operand_a (operand_a),
        .i_operand_b (operand_b),
        .i_shamt     (i_imm[10:6]),
        .o_result    (alu_result)
    );

    branch_unit u_branch_unit (
        .i_branch        (i_branch),
        .i_enable_stage  (i_enable_stage),
        .i_adder_pc      (i_adder_pc),
        .i_imm           (i_imm),
        .i_data_a        (fwd_data_a),
        .i_data_b        (fwd_data_b),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target)
    );

    // Store data is the forwarded rt value.
    ex_mem_latch u_ex_mem_latch (
        .i_clock           (i_clock),
        .i_soft_reset      (i_soft_reset),
        .i_enable_pipeline (i_enable_pipeline),
        .i_reg_write       (i_reg_write),
        .i_mem_read        (i_mem_read),
        .i_mem_write       (i_mem_write),
        .i_mem_to_reg      (i_mem_to_reg),
        .i_halt            (i_halt),
        .i_branch_taken    (o_branch_taken),
        .i_byte_sel        (i_byte_sel),
        .i_result          (alu_result),
        .i_store_data      (fwd_data_b),
        .i_dest_reg        (dest_reg),
        .i_branch_target   (o_branch_target),
        .o_reg_write       (o_reg_write),
        .o_mem_read        (o_mem_read),
        .o_mem_write       (o_mem_write),
        .o_mem_to_reg      (o_mem_to_reg),
        .o_halt            (o_halt),
        .o_branch_taken_q  (o_branch_taken_q),
        .o_byte_sel        (o_byte_sel),
        .o_result          (o_result),
        .o_store_data      (o_store_data),
        .o_dest_reg        (o_dest_reg),
        .o_branch_target_q (o_branch_target_q)
    );

endmodule

`default_nettype wire

//--- logic/forwarding_unit.sv
`default_nettype none

module forwarding_unit
    import execute_pkg::*;
(
    input  wire reg_idx_t i_reg_rs,
    input  wire reg_idx_t i_reg_rt,
    input  wire logic     i_mem_reg_write,
    input  wire reg_idx_t i_mem_dest,
    input  wire logic     i_wb_reg_write,
    input  wire reg_idx_t i_wb_dest,
    output fwd_sel_t      o_fwd_a,
    output fwd_sel_t      o_fwd_b
);

    // Hazard test for one source register, MEM first.
    function automatic fwd_sel_t pick_source(input reg_idx_t src);
        logic mem_hit;
        logic wb_hit;
        mem_hit = i_mem_reg_write && (i_mem_dest == src) && (src != '0);
        wb_hit  = i_wb_reg_write && (i_wb_dest == src) && (src != '0);
        if (mem_hit) begin
            return FWD_MEM;
        end
        else if (wb_hit) begin
            return FWD_WB;
        end
        else begin
            return FWD_NONE;
        end
    endfunction

    always_comb begin
        o_fwd_a = pick_source(i_reg_rs);
        o_fwd_b = pick_source(i_reg_rt);
    end

endmodule

`default_nettype wire

//--- logic/operand_select.sv
`default_nettype none

`include "execute_settings.svh"

module operand_select
    import execute_pkg::*;
(
    input  wire fwd_sel_t i_fwd_a,
    input  wire fwd_sel_t i_fwd_b,
    input  wire data_t    i_data_a,
    input  wire data_t    i_data_b,
    input  wire data_t    i_imm,
    input  wire data_t    i_data_forward_mem,
    input  wire data_t    i_data_forward_wb,
    input  wire addr_t    i_adder_pc,
    input  wire logic     i_alu_src,
    input  wire logic     i_reg_dst,
    input  wire alu_op_t  i_alu_op,
    input  wire reg_idx_t i_reg_rt,
    input  wire reg_idx_t i_reg_rd,
    output data_t         o_fwd_data_a,
    output data_t         o_fwd_data_b,
    output data_t         o_operand_a,
    output data_t         o_operand_b,
    output reg_idx_t      o_dest_reg
);

    function automatic data_t fwd_mux(input fwd_sel_t sel, input data_t reg_value);
        case (sel)
            FWD_MEM: return i_data_forward_mem;
            FWD_WB:  return i_data_forward_wb;
            default: return reg_value;
        endcase
    endfunction

    //////////////////////////////
    // Forwarded register values.
    //////////////////////////////
    always_comb begin
        o_fwd_data_a = fwd_mux(i_fwd_a, i_data_a);
        o_fwd_data_b = fwd_mux(i_fwd_b, i_data_b);
    end

    // Link takes the return address instead of rs.
    always_comb begin
        if (i_alu_op == ALU_LINK) begin
            o_operand_a = {{(`EXE_DATA_W - `EXE_ADDR_W){1'b0}}, i_adder_pc};
        end
        else begin
            o_operand_a = o_fwd_data_a;
        end
        o_operand_b = i_alu_src ? i_imm : o_fwd_data_b;
    end

    assign o_dest_reg = i_reg_dst ? i_reg_rd : i_reg_rt;

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/execute_pkg.sv
logic/forwarding_unit.sv
logic/operand_select.sv
logic/alu.sv
logic/branch_unit.sv
logic/ex_mem_latch.sv
logic/execute_stage.sv
tb/tb_execute_stage.sv

//--- tb/tb_execute_stage.sv
`default_nettype none

module tb_execute_stage
    import execute_pkg::*;
();

    localparam int CLOCK_PERIOD = 8;
    localparam int RESET_CYCLES = 16;
    localparam int ALU_CYCLES   = 200;
    localparam int FWD_CYCLES   = 120;
    localparam int BR_CYCLES    = 150;
    localparam int STALL_ROUNDS = 40;
    localparam int STALL_MAX    = 4;
    localparam int PASS_CYCLES  = 100;
    localparam int TOTAL_CYCLES = RESET_CYCLES + ALU_CYCLES + FWD_CYCLES + BR_CYCLES
                                + STALL_ROUNDS * (STALL_MAX + 1) + PASS_CYCLES + 12;
    localparam int TIMEOUT_TIME = (TOTAL_CYCLES + 40) * CLOCK_PERIOD;

    logic     i_clock = 1'b0;
    logic     i_soft_reset, i_enable_pipeline, i_enable_stage;
    logic     i_halt, i_reg_dst, i_reg_write, i_alu_src, i_mem_read, i_mem_write;
    logic     i_mem_to_reg, i_wb_reg_write;
    branch_t  i_branch;
    alu_op_t  i_alu_op;
    addr_t    i_adder_pc;
    data_t    i_data_a, i_data_b, i_imm, i_data_forward_mem, i_data_forward_wb;
    reg_idx_t i_reg_rs, i_reg_rt, i_reg_rd, i_wb_dest;
    bytesel_t i_byte_sel;

    logic     o_branch_taken, o_reg_write, o_mem_read, o_mem_write, o_mem_to_reg;
    logic     o_halt, o_branch_taken_q;
    addr_t    o_branch_target, o_branch_target_q;
    bytesel_t o_byte_sel;
    data_t    o_result, o_store_data;
    reg_idx_t o_dest_reg;

    // Expected EX/MEM contents, kept by the model.
    logic     q_reg_write, q_mem_read, q_mem_write, q_mem_to_reg, q_halt, q_taken;
    logic     q_target_known;
    bytesel_t q_byte_sel;
    data_t    q_result, q_store;
    reg_idx_t q_dest_reg;
    addr_t    q_target;

    logic     m_taken, m_target_known;
    data_t    m_result, m_store;
    reg_idx_t m_dest;
    addr_t    m_target;

    int seed = 61;
    int check_count = 0;
    int error_count = 0;
    int checks_mark = 0;
    int errors_mark = 0;
    int stall_len;

    execute_stage UUT (.*);

    initial begin
        forever begin
            #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
        end
    end

    //////////////////////////////
    // Reference model.
    //////////////////////////////
    function automatic data_t forward_value(input reg_idx_t src, input data_t reg_value,
                                            input logic mem_rw, input reg_idx_t mem_dest);
        if (src != 5'd0 && mem_rw && mem_dest == src) begin
            return i_data_forward_mem;
        end
        if (src != 5'd0 && i_wb_reg_write && i_wb_dest == src) begin
            return i_data_forward_wb;
        end
        return reg_value;
    endfunction

    function automatic void exe_model(
        input  logic     mem_rw,
        input  reg_idx_t mem_dest,
        output data_t    result,
        output data_t    store,
        output reg_idx_t dest,
        output logic     taken,
        output addr_t    target,
        output logic     target_known
    );
        data_t       a;
        data_t       b;
        data_t       op_a;
        data_t       op_b;
        logic [4:0]  sh_imm;
        logic [4:0]  sh_var;
        logic [63:0] wide;
        a      = forward_value(i_reg_rs, i_data_a, mem_rw, mem_dest);
        b      = forward_value(i_reg_rt, i_data_b, mem_rw, mem_dest);
        op_a   = (i_alu_op == ALU_LINK) ? data_t'(i_adder_pc) : a;
        op_b   = i_alu_src ? i_imm : b;
        sh_imm = i_imm[10:6];
        sh_var = op_a[4:0];
        wide   = '0;
        case (i_alu_op)
            ALU_SLL:  result = op_b << sh_imm;
            ALU_SRL:  result = op_b >> sh_imm;
            ALU_SRA: begin
                wide   = {{32{op_b[31]}}, op_b} >> sh_imm;
                result = wide[31:0];
            end
            ALU_SLLV: result = op_b << sh_var;
            ALU_SRLV: result = op_b >> sh_var;
            ALU_SRAV: begin
                wide   = {{32{op_b[31]}}, op_b} >> sh_var;
                result = wide[31:0];
            end
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_NOR:  result = ~(op_a | op_b);
            ALU_SLT:  result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            ALU_LUI:  result = {op_b[15:0], 16'h0000};
            ALU_LINK: result = op_a + 32'd1;
            default:  result = '0;
        endcase
        store        = b;
        dest         = i_reg_dst ? i_reg_rd : i_reg_rt;
        target_known = 1'b1;
        case (i_branch)
            BR_BEQ: begin
                taken  = (a == b);
                target = i_adder_pc + i_imm[9:0];
            end
            BR_BNE: begin
                taken  = (a != b);
                target = i_adder_pc + i_imm[9:0];
            end
            BR_JUMP: begin
                taken  = 1'b1;
                target = i_imm[9:0];
            end
            BR_JUMP_REG: begin
                taken  = 1'b1;
                target = a[9:0];
            end
            // No branch, so the target is free.
            default: begin
                taken        = 1'b0;
                target       = '0;
                target_known = 1'b0;
            end
        endcase
        taken = taken && i_enable_stage;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic randomize_inputs();
        logic [15:0] half;
        half               = 16'($random(seed));
        i_enable_pipeline  = 1'b1;
        i_enable_stage     = 1'b1;
        i_branch           = branch_t'(rand_below(5));
        i_alu_op           = alu_op_t'(rand_below(15));
        i_adder_pc         = addr_t'($random(seed));
        i_data_a           = data_t'($random(seed));
        i_data_b           = data_t'($random(seed));
        i_imm              = {{16{half[15]}}, half};
        i_reg_rs           = reg_idx_t'($random(seed));
        i_reg_rt           = reg_idx_t'($random(seed));
        i_reg_rd           = reg_idx_t'($random(seed));
        i_halt             = 1'($random(seed));
        i_reg_dst          = 1'($random(seed));
        i_reg_write        = 1'($random(seed));
        i_alu_src          = 1'($random(seed));
        i_mem_read         = 1'($random(seed));
        i_mem_write        = 1'($random(seed));
        i_mem_to_reg       = 1'($random(seed));
        i_byte_sel         = bytesel_t'($random(seed));
        i_wb_reg_write     = 1'($random(seed));
        i_wb_dest          = reg_idx_t'($random(seed));
        i_data_forward_mem = data_t'($random(seed));
        i_data_forward_wb  = data_t'($random(seed));
    endtask

    //////////////////////////////
    // Checking.
    //////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic update_latch_model();
        if (!i_soft_reset) begin
            {q_reg_write, q_mem_read, q_mem_write, q_mem_to_reg, q_halt, q_taken} = '0;
            q_byte_sel     = '0;
            q_result       = '0;
            q_store        = '0;
            q_dest_reg     = '0;
            q_target       = '0;
            q_target_known = 1'b1;
        end
        else if (i_enable_pipeline) begin
            q_reg_write    = i_reg_write;
            q_mem_read     = i_mem_read;
            q_mem_write    = i_mem_write;
            q_mem_to_reg   = i_mem_to_reg;
            q_halt         = i_halt;
            q_taken        = m_taken;
            q_byte_sel     = i_byte_sel;
            q_result       = m_result;
            q_store        = m_store;
            q_dest_reg     = m_dest;
            q_target       = m_target;
            q_target_known = m_target_known;
        end
    endtask

    task automatic check_latched();
        check_value("o_reg_write", 32'(q_reg_write), 32'(o_reg_write));
        check_value("o_mem_read", 32'(q_mem_read), 32'(o_mem_read));
        check_value("o_mem_write", 32'(q_mem_write), 32'(o_mem_write));
        check_value("o_mem_to_reg", 32'(q_mem_to_reg), 32'(o_mem_to_reg));
        check_value("o_halt", 32'(q_halt), 32'(o_halt));
        check_value("o_branch_taken_q", 32'(q_taken), 32'(o_branch_taken_q));
        check_value("o_byte_sel", 32'(q_byte_sel), 32'(o_byte_sel));
        check_value("o_result", q_result, o_result);
        check_value("o_store_data", q_store, o_store_data);
        check_value("o_dest_reg", 32'(q_dest_reg), 32'(o_dest_reg));
        if (q_target_known) begin
            check_value("o_branch_target_q", 32'(q_target), 32'(o_branch_target_q));
        end
    endtask

    // Branch outputs just before the edge, latch just after.
    initial begin : compare
        forever begin
            @(negedge i_clock);
            #(CLOCK_PERIOD / 2 - 1);
            exe_model(q_reg_write, q_dest_reg, m_result, m_store, m_dest, m_taken, m_target,
                      m_target_known);
            check_value("o_branch_taken", 32'(m_taken), 32'(o_branch_taken));
            if (m_target_known) begin
                check_value("o_branch_target", 32'(m_target), 32'(o_branch_target));
            end
            @(posedge i_clock);
            #1;
            update_latch_model();
            check_latched();
        end
    end

    task automatic report_test(input string name);
        int errs;
        @(posedge i_clock);
        #2;
        errs = error_count - errors_mark;
        $display("test %-12s %0d checks, %0d errors, %s", name, check_count - checks_mark,
                 errs, (errs == 0) ? "ok" : "failed");
        checks_mark = check_count;
        errors_mark = error_count;
    endtask

    //////////////////////////////
    // Stimulus.
    //////////////////////////////
    initial begin : stimulus
        {i_soft_reset, i_enable_pipeline, i_enable_stage, i_halt, i_reg_dst} = '0;
        {i_reg_write, i_alu_src, i_mem_read, i_mem_write, i_mem_to_reg} = '0;
        i_wb_reg_write = 1'b0;
        i_branch       = BR_NONE;
        i_alu_op       = ALU_SLL;
        {i_adder_pc, i_data_a, i_data_b, i_imm} = '0;
        {i_data_forward_mem, i_data_forward_wb} = '0;
        {i_reg_rs, i_reg_rt, i_reg_rd, i_wb_dest, i_byte_sel} = '0;
        {q_reg_write, q_mem_read, q_mem_write, q_mem_to_reg, q_halt, q_taken} = '0;
        {q_byte_sel, q_result, q_store, q_dest_reg, q_target} = '0;
        q_target_known = 1'b1;

        // Reset must win over an enabled pipeline.
        // The first clock period passes before this loop.
        repeat (RESET_CYCLES - 1) begin
            @(negedge i_clock);
            randomize_inputs();
        end
        report_test("reset");
        @(negedge i_clock);
        i_soft_reset = 1'b1;

        for (int k = 0; k < ALU_CYCLES; k++) begin
            @(negedge i_clock);
            randomize_inputs();
            i_alu_op       = alu_op_t'(k % 15);
            i_reg_write    = 1'b0;
            i_wb_reg_write = 1'b0;
        end
        report_test("alu");

        // Few registers, so hazards are frequent.
        repeat (FWD_CYCLES) begin
            @(negedge i_clock);
            randomize_inputs();
            i_alu_op    = alu_op_t'(6 + rand_below(6));
            i_alu_src   = 1'b0;
            i_reg_write = (rand_below(4) != 0);
            i_reg_rs    = reg_idx_t'(rand_below(4));
            i_reg_rt    = reg_idx_t'(rand_below(4));
            i_reg_rd    = reg_idx_t'(rand_below(4));
            i_wb_dest   = reg_idx_t'(rand_below(4));
        end
        report_test("forwarding");

        repeat (BR_CYCLES) begin
            @(negedge i_clock);
            randomize_inputs();
            i_enable_stage = 1'($random(seed));
            i_reg_write    = 1'b0;
            i_wb_reg_write = 1'b0;
            if (rand_below(2) == 0) begin
                i_data_b = i_data_a;
            end
        end
        report_test("branch");

        repeat (STALL_ROUNDS) begin
            @(negedge i_clock);
            randomize_inputs();
            stall_len = 1 + rand_below(STALL_MAX);
            repeat (stall_len) begin
                @(negedge i_clock);
                randomize_inputs();
                i_enable_pipeline = 1'b0;
            end
        end
        report_test("stall");

        repeat (PASS_CYCLES) begin
            @(negedge i_clock);
            randomize_inputs();
        end
        report_test("pass-through");

        $display("total %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end
        else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_TIME);
        $display("Timeout: the tests did not reach their end in time.");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
